//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cache_memctrl
RTL_TOP    := cache_memctrl
FILELIST   := cache_memctrl.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- cache_memctrl.f
source/cache_geom_pkg.sv
source/cache_dir_pkg.sv
source/dir_init_fsm.sv
source/tag_directory.sv
source/plru_victim.sv
source/data_array.sv
source/cache_memctrl.sv
testbench/tb_clock.sv
testbench/tb_cache_memctrl.sv

//--- source/cache_dir_pkg.sv
// Directory entry type and init sequencer states, shared by the directory side of the controller
package cache_dir_pkg;

    // Directory entry, tag only
    typedef logic [cache_geom_pkg::TAG_WIDTH-1:0] dir_entry_t;

    // Init sequencer: sweep the sets, then serve requests
    typedef enum logic {
        CLEARING = 1'b0,
        READY    = 1'b1
    } init_state_e;

endpackage

//--- source/cache_geom_pkg.sv
// Cache geometry constants and width types, referenced by scoped name from RTL and testbench
package cache_geom_pkg;

    // Organisation of the cache
    localparam int unsigned SETS       = 16;
    localparam int unsigned WAYS       = 4;
    localparam int unsigned LINE_WORDS = 4;

    // Field widths
    localparam int unsigned TAG_WIDTH       = 8;
    localparam int unsigned DATA_WIDTH      = 32;
    localparam int unsigned SET_WIDTH       = $clog2(SETS);
    localparam int unsigned WORD_IDX_WIDTH  = $clog2(LINE_WORDS);
    localparam int unsigned BE_WIDTH        = DATA_WIDTH / 8;

    // Data RAM holds one word per way for every word of every line
    localparam int unsigned DATA_ADDR_WIDTH = SET_WIDTH + WORD_IDX_WIDTH;
    localparam int unsigned DATA_DEPTH      = SETS * LINE_WORDS;

    // Set index
    typedef logic [SET_WIDTH-1:0]       set_t;

    // Address tag stored in the directory
    typedef logic [TAG_WIDTH-1:0]       tag_t;

    // One bit per way, one-hot for hits and victims
    typedef logic [WAYS-1:0]            way_vec_t;

    // Word offset within a line
    typedef logic [WORD_IDX_WIDTH-1:0]  word_idx_t;

    // Request and refill data word
    typedef logic [DATA_WIDTH-1:0]      data_word_t;

    // Byte enables of a data word
    typedef logic [BE_WIDTH-1:0]        byte_en_t;

    // Data RAM word address, set * LINE_WORDS + word
    typedef logic [DATA_ADDR_WIDTH-1:0] data_addr_t;

endpackage

//--- source/cache_memctrl.sv
// Cache memory controller top; connects init sequencer, directory, PLRU and data array
module cache_memctrl (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    output logic                       ready_o,

    // Directory lookup
    input  logic                       dir_match_i,
    input  cache_geom_pkg::set_t       dir_match_set_i,
    input  cache_geom_pkg::tag_t       dir_match_tag_i,
    input  logic                       dir_update_lru_i,
    output cache_geom_pkg::way_vec_t   dir_hit_way_o,

    // Directory refill
    input  logic                       dir_refill_i,
    input  cache_geom_pkg::set_t       dir_refill_set_i,
    input  cache_geom_pkg::tag_t       dir_refill_tag_i,
    input  logic                       dir_refill_updt_plru_i,
    output cache_geom_pkg::way_vec_t   dir_victim_way_o,

    // Data read
    input  logic                       data_req_read_i,
    input  cache_geom_pkg::set_t       data_req_read_set_i,
    input  cache_geom_pkg::word_idx_t  data_req_read_word_i,
    output cache_geom_pkg::data_word_t data_req_read_data_o,

    // Data write
    input  logic                       data_req_write_i,
    input  logic                       data_req_write_enable_i,
    input  cache_geom_pkg::set_t       data_req_write_set_i,
    input  cache_geom_pkg::word_idx_t  data_req_write_word_i,
    input  cache_geom_pkg::data_word_t data_req_write_data_i,
    input  cache_geom_pkg::byte_en_t   data_req_write_be_i,

    // Data refill
    input  logic                       data_refill_i,
    input  cache_geom_pkg::way_vec_t   data_refill_way_i,
    input  cache_geom_pkg::set_t       data_refill_set_i,
    input  cache_geom_pkg::word_idx_t  data_refill_word_i,
    input  cache_geom_pkg::data_word_t data_refill_data_i
);

    logic                      init_busy;
    cache_geom_pkg::set_t      init_set;
    cache_geom_pkg::set_t      lookup_set;
    cache_geom_pkg::way_vec_t  refill_valid;
    cache_dir_pkg::dir_entry_t refill_entry;

    // Entry written on refill carries only the tag
    assign refill_entry = cache_dir_pkg::dir_entry_t'(dir_refill_tag_i);

    dir_init_fsm u_init (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .init_busy_o (init_busy),
        .init_set_o  (init_set),
        .ready_o     (ready_o)
    );

    tag_directory u_dir (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_busy_i    (init_busy),
        .init_set_i     (init_set),
        .match_i        (dir_match_i),
        .match_set_i    (dir_match_set_i),
        .match_tag_i    (dir_match_tag_i),
        .refill_i       (dir_refill_i),
        .refill_set_i   (dir_refill_set_i),
        .refill_tag_i   (refill_entry),
        .victim_way_i   (dir_victim_way_o),
        .hit_way_o      (dir_hit_way_o),
        .lookup_set_o   (lookup_set),
        .refill_valid_o (refill_valid)
    );

    // Hits are marked in the set of the last lookup
    plru_victim u_plru (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .updt_i       (dir_update_lru_i),
        .updt_set_i   (lookup_set),
        .updt_way_i   (dir_hit_way_o),
        .repl_i       (dir_refill_i),
        .repl_set_i   (dir_refill_set_i),
        .repl_valid_i (refill_valid),
        .repl_updt_i  (dir_refill_updt_plru_i),
        .victim_way_o (dir_victim_way_o)
    );

    data_array u_data (
        .clk_i          (clk_i),
        .read_i         (data_req_read_i),
        .read_set_i     (data_req_read_set_i),
        .read_word_i    (data_req_read_word_i),
        .write_i        (data_req_write_i),
        .write_enable_i (data_req_write_enable_i),
        .write_set_i    (data_req_write_set_i),
        .write_word_i   (data_req_write_word_i),
        .write_data_i   (data_req_write_data_i),
        .write_be_i     (data_req_write_be_i),
        .refill_i       (data_refill_i),
        .refill_way_i   (data_refill_way_i),
        .refill_set_i   (data_refill_set_i),
        .refill_word_i  (data_refill_word_i),
        .refill_data_i  (data_refill_data_i),
        .hit_way_i      (dir_hit_way_o),
        .read_data_o    (data_req_read_data_o)
    );

endmodule

//--- source/data_array.sv
// Data words of all ways with byte-merged writes, word refills and hit-selected reads
module data_array (
    input  logic                       clk_i,
    input  logic                       read_i,
    input  cache_geom_pkg::set_t       read_set_i,
    input  cache_geom_pkg::word_idx_t  read_word_i,
    input  logic                       write_i,
    input  logic                       write_enable_i,
    input  cache_geom_pkg::set_t       write_set_i,
    input  cache_geom_pkg::word_idx_t  write_word_i,
    input  cache_geom_pkg::data_word_t write_data_i,
    input  cache_geom_pkg::byte_en_t   write_be_i,
    input  logic                       refill_i,
    input  cache_geom_pkg::way_vec_t   refill_way_i,
    input  cache_geom_pkg::set_t       refill_set_i,
    input  cache_geom_pkg::word_idx_t  refill_word_i,
    input  cache_geom_pkg::data_word_t refill_data_i,
    input  cache_geom_pkg::way_vec_t   hit_way_i,
    output cache_geom_pkg::data_word_t read_data_o
);

    cache_geom_pkg::data_word_t ram [cache_geom_pkg::WAYS][cache_geom_pkg::DATA_DEPTH];
    cache_geom_pkg::data_word_t rdata_q [cache_geom_pkg::WAYS];

    cache_geom_pkg::data_addr_t addr;
    cache_geom_pkg::way_vec_t   wr_way;
    cache_geom_pkg::data_word_t wdata;
    cache_geom_pkg::byte_en_t   wbe;

    function automatic cache_geom_pkg::data_addr_t to_addr(cache_geom_pkg::set_t set,
                                                           cache_geom_pkg::word_idx_t word);
        return cache_geom_pkg::data_addr_t'(set) *
               cache_geom_pkg::data_addr_t'(cache_geom_pkg::LINE_WORDS) +
               cache_geom_pkg::data_addr_t'(word);
    endfunction

    always_comb begin
        if (refill_i) begin
            addr   = to_addr(refill_set_i, refill_word_i);
            wr_way = refill_way_i;
            wdata  = refill_data_i;
            wbe    = '1;
        end else if (write_i) begin
            // Request writes go to the way hit by the preceding lookup
            addr   = to_addr(write_set_i, write_word_i);
            wr_way = write_enable_i ? hit_way_i : '0;
            wdata  = write_data_i;
            wbe    = write_be_i;
        end else begin
            addr   = to_addr(read_set_i, read_word_i);
            wr_way = '0;
            wdata  = '0;
            wbe    = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            for (int b = 0; b < cache_geom_pkg::BE_WIDTH; b++) begin
                if (wr_way[w] && wbe[b]) begin
                    ram[w][addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            if (read_i) begin
                rdata_q[w] <= ram[w][addr];
            end
        end
    end

    // Hit vector is one-hot or zero, so an OR works as the way mux
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (hit_way_i[w]) begin
                read_data_o = read_data_o | rdata_q[w];
            end
        end
    end

    data_access_excl: assert property (@(posedge clk_i)
        $onehot0({read_i, write_i, refill_i}))
        else $error("data_array: more than one data operation in a cycle");

endmodule

//--- source/dir_init_fsm.sv
// Clears every directory set after reset, one per cycle, then holds ready_o high
module dir_init_fsm (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    output logic                 init_busy_o,
    output cache_geom_pkg::set_t init_set_o,
    output logic                 ready_o
);

    cache_dir_pkg::init_state_e state_q, state_d;
    cache_geom_pkg::set_t       set_q, set_d;
    logic                       last_set;

    assign last_set = (set_q == cache_geom_pkg::set_t'(cache_geom_pkg::SETS - 1));

    always_comb begin
        state_d = state_q;
        set_d   = set_q;
        case (state_q)
            cache_dir_pkg::CLEARING: begin
                set_d = set_q + 1'b1;
                // Leave once the last set is written this cycle
                if (last_set) begin
                    state_d = cache_dir_pkg::READY;
                end
            end
            cache_dir_pkg::READY: begin
                state_d = cache_dir_pkg::READY;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= cache_dir_pkg::CLEARING;
            set_q   <= '0;
        end else begin
            state_q <= state_d;
            set_q   <= set_d;
        end
    end

    assign init_busy_o = (state_q == cache_dir_pkg::CLEARING);
    assign init_set_o  = set_q;
    assign ready_o     = (state_q == cache_dir_pkg::READY);

endmodule

//--- source/plru_victim.sv
// Pseudo-LRU used bits per set; picks the refill victim and marks ways on hits and refills
module plru_victim (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     updt_i,
    input  cache_geom_pkg::set_t     updt_set_i,
    input  cache_geom_pkg::way_vec_t updt_way_i,
    input  logic                     repl_i,
    input  cache_geom_pkg::set_t     repl_set_i,
    input  cache_geom_pkg::way_vec_t repl_valid_i,
    input  logic                     repl_updt_i,
    output cache_geom_pkg::way_vec_t victim_way_o
);

    cache_geom_pkg::way_vec_t [cache_geom_pkg::SETS-1:0] used_q;
    cache_geom_pkg::way_vec_t repl_used;

    // One-hot of the lowest set bit, zero if none
    function automatic cache_geom_pkg::way_vec_t lowest_one(cache_geom_pkg::way_vec_t v);
        cache_geom_pkg::way_vec_t sel;
        sel = '0;
        for (int i = cache_geom_pkg::WAYS - 1; i >= 0; i--) begin
            if (v[i]) begin
                sel    = '0;
                sel[i] = 1'b1;
            end
        end
        return sel;
    endfunction

    // Set the way's bit; start a new round when every bit would be set
    function automatic cache_geom_pkg::way_vec_t mark_used(cache_geom_pkg::way_vec_t used,
                                                           cache_geom_pkg::way_vec_t way);
        cache_geom_pkg::way_vec_t nxt;
        nxt = used | way;
        if (&nxt) begin
            nxt = way;
        end
        return nxt;
    endfunction

    assign repl_used = used_q[repl_set_i];

    // Invalid ways go first, then the lowest way not recently used
    assign victim_way_o = (&repl_valid_i) ? lowest_one(~repl_used)
                                          : lowest_one(~repl_valid_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            used_q <= '0;
        end else begin
            if (updt_i) begin
                used_q[updt_set_i] <= mark_used(used_q[updt_set_i], updt_way_i);
            end
            if (repl_i && repl_updt_i) begin
                used_q[repl_set_i] <= mark_used(repl_used, victim_way_o);
            end
        end
    end

endmodule

//--- source/tag_directory.sv
// Tag RAM and valid bits of the directory; lookups report the hit way one cycle later
module tag_directory (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     init_busy_i,
    input  cache_geom_pkg::set_t     init_set_i,
    input  logic                     match_i,
    input  cache_geom_pkg::set_t     match_set_i,
    input  cache_geom_pkg::tag_t     match_tag_i,
    input  logic                     refill_i,
    input  cache_geom_pkg::set_t     refill_set_i,
    input  cache_geom_pkg::tag_t     refill_tag_i,
    input  cache_geom_pkg::way_vec_t victim_way_i,
    output cache_geom_pkg::way_vec_t hit_way_o,
    output cache_geom_pkg::set_t     lookup_set_o,
    output cache_geom_pkg::way_vec_t refill_valid_o
);

    cache_dir_pkg::dir_entry_t tag_ram [cache_geom_pkg::WAYS][cache_geom_pkg::SETS];
    cache_dir_pkg::dir_entry_t rentry_q [cache_geom_pkg::WAYS];

    cache_geom_pkg::way_vec_t [cache_geom_pkg::SETS-1:0] valid_q;

    cache_geom_pkg::way_vec_t  lookup_valid_q;
    cache_geom_pkg::set_t      lookup_set_q;
    cache_geom_pkg::tag_t      lookup_tag_q;

    logic                      lookup_go;
    logic                      refill_go;
    cache_geom_pkg::set_t      dir_addr;
    cache_geom_pkg::way_vec_t  dir_we;
    cache_dir_pkg::dir_entry_t dir_wentry;

    // Port priority is init, then lookup, then refill
    assign lookup_go = match_i & ~init_busy_i;
    assign refill_go = refill_i & ~init_busy_i & ~match_i;

    always_comb begin
        dir_addr   = '0;
        dir_we     = '0;
        dir_wentry = '0;
        if (init_busy_i) begin
            dir_addr = init_set_i;
            dir_we   = '1;
        end else if (match_i) begin
            dir_addr = match_set_i;
        end else if (refill_i) begin
            dir_addr   = refill_set_i;
            dir_we     = victim_way_i;
            dir_wentry = cache_dir_pkg::dir_entry_t'(refill_tag_i);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (dir_we[w]) begin
                tag_ram[w][dir_addr] <= dir_wentry;
            end
            if (lookup_go) begin
                rentry_q[w] <= tag_ram[w][dir_addr];
            end
        end
    end

    // Valid bits, cleared by the init sweep and set by refills
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (init_busy_i) begin
            valid_q[init_set_i] <= '0;
        end else if (refill_go) begin
            valid_q[refill_set_i] <= valid_q[refill_set_i] | victim_way_i;
        end
    end

    // Valid snapshot keeps the hit vector steady until the next lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_valid_q <= '0;
        end else if (lookup_go) begin
            lookup_valid_q <= valid_q[match_set_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_go) begin
            lookup_set_q <= match_set_i;
            lookup_tag_q <= match_tag_i;
        end
    end

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            hit_way_o[w] = lookup_valid_q[w] & (rentry_q[w] == lookup_tag_q);
        end
    end

    assign lookup_set_o   = lookup_set_q;
    assign refill_valid_o = valid_q[refill_set_i];

    dir_access_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(match_i && refill_i))
        else $error("tag_directory: lookup and refill in the same cycle");

endmodule

//--- testbench/memctrl_tests.txt
# I: ready cycle | L,T: set tag hit | R: set tag plru_updt victim | F: way set word data
# D: set tag word read_data | W: set tag word data write_enable hit (byte enables from LFSR)
I 11
L 0 AA 0
R 3 10 1 1
R 3 11 1 2
R 3 12 1 4
R 3 13 1 8
L 3 10 1
L 3 11 2
L 3 12 4
L 3 13 8
L 3 55 0
T 3 10 1
T 3 12 4
R 3 21 1 2
R 3 20 0 1
L 3 20 1
L 3 21 2
L 3 11 0
R 5 40 1 1
R 5 41 1 2
F 2 5 0 11112222
F 2 5 1 33334444
F 2 5 2 55556666
F 2 5 3 77778888
D 5 41 0 11112222
D 5 41 2 55556666
D 5 99 1 0
W 5 41 1 AABBCCDD 1 2
D 5 41 1 33BBCC44
W 5 41 3 DEADBEEF 1 2
D 5 41 3 77AD8888
W 5 41 0 FFFFFFFF 0 2
D 5 41 0 11112222

//--- testbench/tb_cache_memctrl.sv
// Testbench top for the cache memory controller; runs each line of the tests file against a model
module tb_cache_memctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string       TEST_FILE       = "testbench/memctrl_tests.txt";
    localparam int unsigned CYCLES_PER_TEST = 20;
    localparam time         SETTLE          = 10ns;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       ready_o;
    logic                       dir_match_i;
    cache_geom_pkg::set_t       dir_match_set_i;
    cache_geom_pkg::tag_t       dir_match_tag_i;
    logic                       dir_update_lru_i;
    cache_geom_pkg::way_vec_t   dir_hit_way_o;
    logic                       dir_refill_i;
    cache_geom_pkg::set_t       dir_refill_set_i;
    cache_geom_pkg::tag_t       dir_refill_tag_i;
    logic                       dir_refill_updt_plru_i;
    cache_geom_pkg::way_vec_t   dir_victim_way_o;
    logic                       data_req_read_i;
    cache_geom_pkg::set_t       data_req_read_set_i;
    cache_geom_pkg::word_idx_t  data_req_read_word_i;
    cache_geom_pkg::data_word_t data_req_read_data_o;
    logic                       data_req_write_i;
    logic                       data_req_write_enable_i;
    cache_geom_pkg::set_t       data_req_write_set_i;
    cache_geom_pkg::word_idx_t  data_req_write_word_i;
    cache_geom_pkg::data_word_t data_req_write_data_i;
    cache_geom_pkg::byte_en_t   data_req_write_be_i;
    logic                       data_refill_i;
    cache_geom_pkg::way_vec_t   data_refill_way_i;
    cache_geom_pkg::set_t       data_refill_set_i;
    cache_geom_pkg::word_idx_t  data_refill_word_i;
    cache_geom_pkg::data_word_t data_refill_data_i;

    // Reference model of the directory, PLRU and data words
    cache_geom_pkg::way_vec_t   m_valid [cache_geom_pkg::SETS];
    cache_geom_pkg::way_vec_t   m_used [cache_geom_pkg::SETS];
    cache_geom_pkg::tag_t       m_tag [cache_geom_pkg::SETS][cache_geom_pkg::WAYS];
    cache_geom_pkg::data_word_t m_data [cache_geom_pkg::WAYS][cache_geom_pkg::SETS]
                                       [cache_geom_pkg::LINE_WORDS];

    string       test_lines [$];
    logic [15:0] lfsr_q;
    logic        tests_loaded;
    int          watchdog_cycles;
    int          pass_count;
    int          fail_count;
    int          test_errors;

    tb_clock u_clock (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    cache_memctrl dut (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per enable bit, lowest byte first
    task automatic draw_byte_enables(output cache_geom_pkg::byte_en_t be);
        for (int i = 0; i < cache_geom_pkg::BE_WIDTH; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            be[i]  = lfsr_q[0];
        end
    endtask

    function automatic int way_index(input cache_geom_pkg::way_vec_t vec);
        int idx;
        idx = -1;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (vec[w]) begin
                idx = w;
            end
        end
        return idx;
    endfunction

    function automatic cache_geom_pkg::way_vec_t predict_hit(input cache_geom_pkg::set_t set,
                                                             input cache_geom_pkg::tag_t tag);
        cache_geom_pkg::way_vec_t hit;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            hit[w] = m_valid[set][w] && (m_tag[set][w] == tag);
        end
        return hit;
    endfunction

    // Lowest invalid way first, else lowest way not marked used
    function automatic cache_geom_pkg::way_vec_t predict_victim(input cache_geom_pkg::set_t set);
        cache_geom_pkg::way_vec_t victim;
        int pick;
        pick = -1;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (pick < 0 && !m_valid[set][w]) begin
                pick = w;
            end
        end
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (pick < 0 && !m_used[set][w]) begin
                pick = w;
            end
        end
        victim = '0;
        if (pick >= 0) begin
            victim[pick] = 1'b1;
        end
        return victim;
    endfunction

    function automatic cache_geom_pkg::way_vec_t mark_way(input cache_geom_pkg::way_vec_t used,
                                                          input cache_geom_pkg::way_vec_t way);
        if ((used | way) == '1) begin
            return way;
        end
        return used | way;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic drive_idle();
        dir_match_i             = 1'b0;
        dir_match_set_i         = '0;
        dir_match_tag_i         = '0;
        dir_update_lru_i        = 1'b0;
        dir_refill_i            = 1'b0;
        dir_refill_set_i        = '0;
        dir_refill_tag_i        = '0;
        dir_refill_updt_plru_i  = 1'b0;
        data_req_read_i         = 1'b0;
        data_req_read_set_i     = '0;
        data_req_read_word_i    = '0;
        data_req_write_i        = 1'b0;
        data_req_write_enable_i = 1'b0;
        data_req_write_set_i    = '0;
        data_req_write_word_i   = '0;
        data_req_write_data_i   = '0;
        data_req_write_be_i     = '0;
        data_refill_i           = 1'b0;
        data_refill_way_i       = '0;
        data_refill_set_i       = '0;
        data_refill_word_i      = '0;
        data_refill_data_i      = '0;
    endtask

    task automatic wait_ready();
        while (ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
    endtask

    // Lookup pulse, optionally with a read; returns at the edge where the hit is valid
    task automatic do_lookup(input cache_geom_pkg::set_t set, input cache_geom_pkg::tag_t tag,
                             input logic read, input cache_geom_pkg::word_idx_t word);
        dir_match_i          = 1'b1;
        dir_match_set_i      = set;
        dir_match_tag_i      = tag;
        data_req_read_i      = read;
        data_req_read_set_i  = set;
        data_req_read_word_i = word;
        @(negedge clk_i);
        dir_match_i     = 1'b0;
        data_req_read_i = 1'b0;
    endtask

    task automatic run_line(input int num, input string line);
        byte                        op;
        logic [31:0]                f [6];
        cache_geom_pkg::set_t       set;
        cache_geom_pkg::tag_t       tag;
        cache_geom_pkg::word_idx_t  word;
        cache_geom_pkg::way_vec_t   exp_way;
        cache_geom_pkg::data_word_t exp_data;
        cache_geom_pkg::byte_en_t   be;
        int                         cycles;
        int                         w;
        op = line.getc(0);
        foreach (f[i]) begin
            f[i] = '0;
        end
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5]));
        set         = cache_geom_pkg::set_t'(f[0]);
        tag         = cache_geom_pkg::tag_t'(f[1]);
        word        = cache_geom_pkg::word_idx_t'(f[2]);
        test_errors = 0;
        if (op != "I") begin
            wait_ready();
        end
        case (op)
            "I": begin
                cycles = 1;
                check("ready_o", 32'(ready_o), 32'd0);
                while (ready_o !== 1'b1 && cycles <= 4 * cache_geom_pkg::SETS) begin
                    @(negedge clk_i);
                    cycles++;
                end
                check("ready_o rise cycle", 32'(cycles), 32'(cache_geom_pkg::SETS + 1));
                check("ready_o rise cycle", 32'(cycles), f[0]);
            end
            "L", "T": begin
                do_lookup(set, tag, 1'b0, '0);
                exp_way = predict_hit(set, tag);
                check("dir_hit_way_o", 32'(dir_hit_way_o), 32'(exp_way));
                check("dir_hit_way_o", 32'(dir_hit_way_o), f[2]);
                if (op == "T") begin
                    dir_update_lru_i = 1'b1;
                    m_used[set]      = mark_way(m_used[set], exp_way);
                    @(negedge clk_i);
                    dir_update_lru_i = 1'b0;
                end
            end
            "R": begin
                dir_refill_i           = 1'b1;
                dir_refill_set_i       = set;
                dir_refill_tag_i       = tag;
                dir_refill_updt_plru_i = f[2][0];
                #SETTLE;
                exp_way = predict_victim(set);
                check("dir_victim_way_o", 32'(dir_victim_way_o), 32'(exp_way));
                check("dir_victim_way_o", 32'(dir_victim_way_o), f[3]);
                w = way_index(exp_way);
                if (w >= 0) begin
                    m_tag[set][w]   = tag;
                    m_valid[set][w] = 1'b1;
                    if (f[2][0]) begin
                        m_used[set] = mark_way(m_used[set], exp_way);
                    end
                end
                @(negedge clk_i);
                dir_refill_i           = 1'b0;
                dir_refill_updt_plru_i = 1'b0;
            end
            "F": begin
                data_refill_i      = 1'b1;
                data_refill_way_i  = cache_geom_pkg::way_vec_t'(f[0]);
                data_refill_set_i  = cache_geom_pkg::set_t'(f[1]);
                data_refill_word_i = cache_geom_pkg::word_idx_t'(f[2]);
                data_refill_data_i = f[3];
                w = way_index(cache_geom_pkg::way_vec_t'(f[0]));
                if (w >= 0) begin
                    m_data[w][data_refill_set_i][data_refill_word_i] = f[3];
                end
                @(negedge clk_i);
                data_refill_i = 1'b0;
            end
            "D": begin
                do_lookup(set, tag, 1'b1, word);
                exp_way = predict_hit(set, tag);
                check("dir_hit_way_o", 32'(dir_hit_way_o), 32'(exp_way));
                w        = way_index(exp_way);
                exp_data = (w >= 0) ? m_data[w][set][word] : '0;
                check("data_req_read_data_o", data_req_read_data_o, exp_data);
                check("data_req_read_data_o", data_req_read_data_o, f[3]);
            end
            "W": begin
                do_lookup(set, tag, 1'b0, '0);
                exp_way = predict_hit(set, tag);
                check("dir_hit_way_o", 32'(dir_hit_way_o), 32'(exp_way));
                check("dir_hit_way_o", 32'(dir_hit_way_o), f[5]);
                draw_byte_enables(be);
                data_req_write_i        = 1'b1;
                data_req_write_enable_i = f[4][0];
                data_req_write_set_i    = set;
                data_req_write_word_i   = word;
                data_req_write_data_i   = f[3];
                data_req_write_be_i     = be;
                w = way_index(exp_way);
                if (f[4][0] && w >= 0) begin
                    for (int b = 0; b < cache_geom_pkg::BE_WIDTH; b++) begin
                        if (be[b]) begin
                            m_data[w][set][word][8*b +: 8] = f[3][8*b +: 8];
                        end
                    end
                end
                @(negedge clk_i);
                data_req_write_i        = 1'b0;
                data_req_write_enable_i = 1'b0;
            end
            default: begin
                $display("Test %0d has an unknown operation '%c' in the tests file", num, op);
                test_errors++;
            end
        endcase
        if (test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d op %c: %s", num, op, (test_errors == 0) ? "passed" : "failed");
    endtask

    initial begin : main
        int    fd;
        string line;
        drive_idle();
        for (int s = 0; s < cache_geom_pkg::SETS; s++) begin
            m_valid[s] = '0;
            m_used[s]  = '0;
        end
        lfsr_q       = 16'd64608;
        pass_count   = 0;
        fail_count   = 0;
        tests_loaded = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the tests file %s", TEST_FILE);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    test_lines.push_back(line);
                end
            end
            $fclose(fd);
            watchdog_cycles = CYCLES_PER_TEST * test_lines.size() + cache_geom_pkg::SETS;
            tests_loaded    = 1'b1;
            wait (rst_ni === 1'b1);
            foreach (test_lines[i]) begin
                run_line(i + 1, test_lines[i]);
            end
            $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
            if (fail_count == 0 && pass_count > 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (tests_loaded === 1'b1);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("Timeout: tests still running after %0d clock cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
// Testbench clock and reset source: 100 ns clock, reset held low for three cycles
module tb_clock (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time PERIOD = 100ns;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge so the first stimulus lines up with it
    initial begin
        rst_no = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule
